/* rename_pkg.sv */
package rename_pkg;

	// machine sizes
	localparam int NUM_ARCH  = 32;
	localparam int NUM_PHYS  = 48;
	localparam int ROB_DEPTH = 8;
	localparam int TAG_W     = 6;
	localparam int ROB_W     = 3;

	// number of tags free at reset above the identity range
	localparam int NUM_FREE = NUM_PHYS - NUM_ARCH;

	// free list slot index wide enough for every physical tag
	localparam int FL_W = $clog2(NUM_PHYS);

	typedef logic [4:0]       arch_reg_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [31:0]      inst_t;

	// one renamed instruction as held in the reorder buffer
	typedef struct packed {
		arch_reg_t dest;     // architectural destination
		tag_t      tag;      // newly allocated physical tag
		tag_t      told;     // previous mapping of dest, freed at retire
		logic      has_dest;
	} rob_entry_t;

	// rv32 major opcodes that get decoded
	localparam logic [6:0] OP_REG    = 7'b0110011;
	localparam logic [6:0] OP_IMM    = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

endpackage

/* rename_if.sv */
`timescale 1ns/100ps

// renamed entries from dispatch into the reorder buffer
interface dispatch_if import rename_pkg::*; ();

	logic       valid;  // entry written at this edge
	rob_entry_t entry;
	logic       full;   // no room so dispatch holds off

	modport producer (
		output valid,
		output entry,
		input  full
	);

	modport buffer (
		input  valid,
		input  entry,
		output full
	);

endinterface

// oldest entry from the reorder buffer to the retire unit
interface retire_if import rename_pkg::*; ();

	logic       head_valid;
	rob_entry_t head;
	logic       pop;        // head leaves at this edge

	modport buffer (
		output head_valid,
		output head,
		input  pop
	);

	modport consumer (
		input  head_valid,
		input  head,
		output pop
	);

endinterface

/* decoder.sv */
`timescale 1ns/100ps

module decoder import rename_pkg::*; (
	input  inst_t     inst,
	input  logic      valid,
	output arch_reg_t rs1,
	output arch_reg_t rs2,
	output arch_reg_t rd,
	output logic      uses_rs2,
	output logic      has_dest
);

	logic [6:0] opcode;
	logic       writes_rd;

	assign opcode = inst[6:0];

	// register fields sit at the same place in every format
	assign rd  = inst[11:7];
	assign rs1 = inst[19:15];
	assign rs2 = inst[24:20];

	always_comb begin
		uses_rs2  = 1'b0;
		writes_rd = 1'b0;
		case (opcode)
			OP_REG: begin
				uses_rs2  = 1'b1;
				writes_rd = 1'b1;
			end
			OP_IMM: begin
				writes_rd = 1'b1;
			end
			OP_LOAD: begin
				writes_rd = 1'b1;
			end
			OP_STORE: begin
				uses_rs2 = 1'b1;  // store data
			end
			OP_BRANCH: begin
				uses_rs2 = 1'b1;  // compare operand
			end
			default: begin
				uses_rs2  = 1'b0;
				writes_rd = 1'b0;
			end
		endcase
	end

	// x0 is hardwired and never renamed
	assign has_dest = valid && writes_rd && (rd != '0);

endmodule

/* free_list.sv */
`timescale 1ns/100ps

module free_list import rename_pkg::*; (
	input  logic clock,
	input  logic reset,
	input  logic alloc,
	input  logic ret_valid,
	input  tag_t ret_tag,
	output tag_t alloc_tag,
	output logic empty
);

	tag_t            slots [NUM_PHYS];
	logic [FL_W-1:0] head;   // oldest free tag
	logic [FL_W-1:0] tail;   // next return goes here
	logic [FL_W:0]   count;

	// queue depth is not a power of two, so wrap by hand
	function automatic logic [FL_W-1:0] ptr_inc(input logic [FL_W-1:0] p);
		return (p == FL_W'(NUM_PHYS - 1)) ? '0 : p + 1'b1;
	endfunction

	assign alloc_tag = slots[head];
	assign empty     = (count == '0);

	always_ff @(posedge clock) begin
		if (reset) begin
			// tags above the architectural range start out free, lowest first
			for (int i = 0; i < NUM_PHYS; i++) begin
				slots[i] <= (i < NUM_FREE) ? tag_t'(NUM_ARCH + i) : '0;
			end
			head  <= '0;
			tail  <= FL_W'(NUM_FREE);
			count <= (FL_W+1)'(NUM_FREE);
		end else begin
			if (alloc) begin
				head <= ptr_inc(head);
			end
			if (ret_valid) begin
				slots[tail] <= ret_tag;
				tail        <= ptr_inc(tail);
			end
			case ({alloc, ret_valid})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

endmodule

/* map_table.sv */
`timescale 1ns/100ps

module map_table import rename_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  arch_reg_t rd_idx_a,
	input  arch_reg_t rd_idx_b,
	input  logic      wr_en,
	input  arch_reg_t wr_idx,
	input  tag_t      wr_tag,
	output tag_t      rd_tag_a,
	output tag_t      rd_tag_b,
	output tag_t      old_tag
);

	tag_t map [NUM_ARCH];  // speculative arch -> phys mapping

	// reads are combinational and see the map before this edge's write,
	// so a source equal to rd still gets the previous tag
	assign rd_tag_a = map[rd_idx_a];
	assign rd_tag_b = map[rd_idx_b];
	assign old_tag  = map[wr_idx];   // mapping being replaced

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				map[i] <= tag_t'(i);  // identity
			end
		end else if (wr_en) begin
			map[wr_idx] <= wr_tag;
		end
	end

endmodule

/* dispatch.sv */
`timescale 1ns/100ps

module dispatch import rename_pkg::*; (
	input  logic   clock,
	input  logic   reset,
	input  logic   inst_valid,
	input  inst_t  inst,
	input  logic   free_valid,
	input  tag_t   free_tag,
	output logic   stall,
	output tag_t   t1,
	output tag_t   t2,
	dispatch_if.producer disp
);

	arch_reg_t rs1;
	arch_reg_t rs2;
	arch_reg_t rd;
	arch_reg_t src_b;
	logic      uses_rs2;
	logic      has_dest;
	logic      accept;
	logic      alloc;
	logic      fl_empty;
	tag_t      new_tag;
	tag_t      old_tag;

	decoder decoder_0 (
		.inst     (inst),
		.valid    (inst_valid),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.uses_rs2 (uses_rs2),
		.has_dest (has_dest)
	);

	assign src_b = uses_rs2 ? rs2 : '0;  // unused operand reads x0

	map_table map_table_0 (
		.clock    (clock),
		.reset    (reset),
		.rd_idx_a (rs1),
		.rd_idx_b (src_b),
		.wr_en    (alloc),
		.wr_idx   (rd),
		.wr_tag   (new_tag),
		.rd_tag_a (t1),
		.rd_tag_b (t2),
		.old_tag  (old_tag)
	);

	free_list free_list_0 (
		.clock     (clock),
		.reset     (reset),
		.alloc     (alloc),
		.ret_valid (free_valid),
		.ret_tag   (free_tag),
		.alloc_tag (new_tag),
		.empty     (fl_empty)
	);

	// only a destination needs a free tag
	assign stall  = disp.full || (has_dest && fl_empty);
	assign accept = inst_valid && !stall;
	assign alloc  = accept && has_dest;  // map write and free list pop

	assign disp.valid          = accept;
	assign disp.entry.dest     = has_dest ? rd : '0;
	assign disp.entry.tag      = has_dest ? new_tag : '0;
	assign disp.entry.told     = has_dest ? old_tag : '0;
	assign disp.entry.has_dest = has_dest;

endmodule

/* rob.sv */
`timescale 1ns/100ps

module rob import rename_pkg::*; (
	input  logic clock,
	input  logic reset,
	dispatch_if.buffer disp,
	retire_if.buffer   ret
);

	rob_entry_t       entries [ROB_DEPTH];
	logic [ROB_W-1:0] head;   // oldest entry
	logic [ROB_W-1:0] tail;   // next free slot
	logic [ROB_W:0]   count;  // one extra bit to tell full from empty

	assign disp.full      = (count == (ROB_W+1)'(ROB_DEPTH));
	assign ret.head_valid = (count != '0);
	assign ret.head       = entries[head];

	// payload storage, written in program order at the tail
	always_ff @(posedge clock) begin
		if (disp.valid) begin
			entries[tail] <= disp.entry;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (disp.valid) begin
				tail <= tail + 1'b1;  // power of two depth wraps naturally
			end
			if (ret.pop) begin
				head <= head + 1'b1;
			end
			case ({disp.valid, ret.pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* retire.sv */
`timescale 1ns/100ps

module retire import rename_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      retire_en,
	input  arch_reg_t arch_idx,
	retire_if.consumer ret,
	output logic      free_valid,
	output tag_t      free_tag,
	output logic      retire_valid,
	output arch_reg_t retire_dest,
	output tag_t      retire_tag,
	output tag_t      arch_tag
);

	tag_t arch_map [NUM_ARCH];  // committed mapping
	logic commit_dest;

	// a request against an empty rob does nothing
	assign ret.pop = retire_en && ret.head_valid;

	assign commit_dest = ret.pop && ret.head.has_dest;

	// the superseded tag goes back to the free list at the pop edge
	assign free_valid = commit_dest;
	assign free_tag   = ret.head.told;

	assign arch_tag = arch_map[arch_idx];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				arch_map[i] <= tag_t'(i);
			end
			retire_valid <= 1'b0;
		end else begin
			if (commit_dest) begin
				arch_map[ret.head.dest] <= ret.head.tag;
			end
			retire_valid <= ret.pop;
		end
	end

	// retired entry shows up one cycle after the pop
	always_ff @(posedge clock) begin
		if (ret.pop) begin
			retire_dest <= ret.head.dest;
			retire_tag  <= ret.head.tag;
		end
	end

endmodule

/* rename_top.sv */
`timescale 1ns/100ps

module rename_top import rename_pkg::*; (
	input  logic      clock,
	input  logic      reset,
	input  logic      inst_valid,
	input  inst_t     inst,
	input  logic      retire_en,
	input  arch_reg_t arch_idx,
	output logic      stall,
	output logic      disp_valid,
	output tag_t      disp_tag,
	output tag_t      disp_t1,
	output tag_t      disp_t2,
	output tag_t      disp_told,
	output logic      retire_valid,
	output arch_reg_t retire_dest,
	output tag_t      retire_tag,
	output tag_t      arch_tag
);

	dispatch_if disp_bus ();
	retire_if   ret_bus ();

	logic free_valid;  // tag freed by retire
	tag_t free_tag;

	dispatch dispatch_0 (
		.clock      (clock),
		.reset      (reset),
		.inst_valid (inst_valid),
		.inst       (inst),
		.free_valid (free_valid),
		.free_tag   (free_tag),
		.stall      (stall),
		.t1         (disp_t1),
		.t2         (disp_t2),
		.disp       (disp_bus.producer)
	);

	rob rob_0 (
		.clock (clock),
		.reset (reset),
		.disp  (disp_bus.buffer),
		.ret   (ret_bus.buffer)
	);

	retire retire_0 (
		.clock        (clock),
		.reset        (reset),
		.retire_en    (retire_en),
		.arch_idx     (arch_idx),
		.ret          (ret_bus.consumer),
		.free_valid   (free_valid),
		.free_tag     (free_tag),
		.retire_valid (retire_valid),
		.retire_dest  (retire_dest),
		.retire_tag   (retire_tag),
		.arch_tag     (arch_tag)
	);

	// observed renamed entry
	assign disp_valid = disp_bus.valid;
	assign disp_tag   = disp_bus.entry.tag;
	assign disp_told  = disp_bus.entry.told;

endmodule

/* rename_tb.sv */
`timescale 1ns/100ps

module rename_tb import rename_pkg::*; ();

	localparam int WAIT_LIMIT = 200;  // cycles before a wait gives up

	logic      clock;
	logic      reset;
	logic      inst_valid;
	inst_t     inst;
	logic      retire_en;
	arch_reg_t arch_idx;
	logic      stall;
	logic      disp_valid;
	tag_t      disp_tag;
	tag_t      disp_t1;
	tag_t      disp_t2;
	tag_t      disp_told;
	logic      retire_valid;
	arch_reg_t retire_dest;
	tag_t      retire_tag;
	tag_t      arch_tag;

	// reference model state
	tag_t       model_map [NUM_ARCH];   // speculative map
	tag_t       model_arch [NUM_ARCH];  // retirement map
	tag_t       free_q [$];
	rob_entry_t rob_q [$];
	logic       exp_ret_valid;
	arch_reg_t  exp_ret_dest;
	tag_t       exp_ret_tag;

	int          errors;
	int          checks;
	int          test_base;
	int          recycled;  // allocations of a tag below the initial free range
	logic [31:0] seed;
	tag_t        last_tag;
	tag_t        last_told;
	tag_t        last_t1;
	tag_t        last_t2;

	rename_top DUT (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic inst_t make_inst(input logic [6:0] op, input arch_reg_t rd,
			input arch_reg_t rs1, input arch_reg_t rs2);
		return {7'd0, rs2, rs1, 3'd0, rd, op};
	endfunction

	function automatic logic writes_reg(input inst_t i);
		logic [6:0] op;
		op = i[6:0];
		return (op == OP_REG || op == OP_IMM || op == OP_LOAD) && (i[11:7] != 5'd0);
	endfunction

	function automatic logic reads_rs2(input inst_t i);
		logic [6:0] op;
		op = i[6:0];
		return op == OP_REG || op == OP_STORE || op == OP_BRANCH;
	endfunction

	// rob full, or a destination with nothing left to allocate
	function automatic logic exp_stall();
		return (rob_q.size() == ROB_DEPTH) ||
			(inst_valid && writes_reg(inst) && free_q.size() == 0);
	endfunction

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic abort(input string what);
		$display("timeout: %s", what);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic end_test(input string name);
		if (errors == test_base)
			$display("test %-16s ok", name);
		else
			$display("test %-16s %0d errors", name, errors - test_base);
		test_base = errors;
	endtask

	// model updates on the same edge as the DUT
	always @(posedge clock) begin : model
		rob_entry_t head;
		rob_entry_t e;
		logic       pop;
		logic       take;
		if (reset) begin
			for (int i = 0; i < NUM_ARCH; i++) begin
				model_map[i]  = tag_t'(i);
				model_arch[i] = tag_t'(i);
			end
			free_q.delete();
			for (int i = NUM_ARCH; i < NUM_PHYS; i++)
				free_q.push_back(tag_t'(i));
			rob_q.delete();
			exp_ret_valid = 1'b0;
		end else begin
			pop  = retire_en && (rob_q.size() != 0);
			take = inst_valid && !exp_stall();
			exp_ret_valid = pop;
			if (pop) begin
				head = rob_q.pop_front();
				exp_ret_dest = head.dest;
				exp_ret_tag  = head.tag;
				if (head.has_dest)
					model_arch[head.dest] = head.tag;
			end
			if (take) begin
				e.has_dest = writes_reg(inst);
				e.dest = e.has_dest ? inst[11:7] : '0;
				e.tag  = e.has_dest ? free_q.pop_front() : '0;
				e.told = e.has_dest ? model_map[inst[11:7]] : '0;
				if (e.has_dest) begin
					model_map[e.dest] = e.tag;
					if (e.tag < NUM_ARCH)
						recycled++;
				end
				rob_q.push_back(e);
			end
			if (pop && head.has_dest)
				free_q.push_back(head.told);  // returned after the allocation so oldest stays first
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clock) begin : compare
		logic valid_exp;
		tag_t t2_exp;
		if (!reset) begin
			valid_exp = inst_valid && !exp_stall();
			t2_exp = reads_rs2(inst) ? model_map[inst[24:20]] : model_map[0];
			check_val("stall", 8'(stall), 8'(exp_stall()));
			check_val("disp_valid", 8'(disp_valid), 8'(valid_exp));
			check_val("disp_t1", 8'(disp_t1), 8'(model_map[inst[19:15]]));
			check_val("disp_t2", 8'(disp_t2), 8'(t2_exp));
			if (valid_exp) begin
				check_val("disp_tag", 8'(disp_tag), writes_reg(inst) ? 8'(free_q[0]) : 8'd0);
				check_val("disp_told", 8'(disp_told),
					writes_reg(inst) ? 8'(model_map[inst[11:7]]) : 8'd0);
			end
			check_val("retire_valid", 8'(retire_valid), 8'(exp_ret_valid));
			if (exp_ret_valid) begin
				check_val("retire_dest", 8'(retire_dest), 8'(exp_ret_dest));
				check_val("retire_tag", 8'(retire_tag), 8'(exp_ret_tag));
			end
			check_val("arch_tag", 8'(arch_tag), 8'(model_arch[arch_idx]));
		end
	end

	// holds the instruction until an edge accepts it
	task automatic wait_accept(input bit random_retire);
		logic [31:0] r;
		bit          taken;
		taken = 1'b0;
		for (int n = 0; n < WAIT_LIMIT && !taken; n++) begin
			if (random_retire) begin
				r = next_rand();
				retire_en = r[31];
			end
			@(negedge clock);
			if (disp_valid) begin
				taken     = 1'b1;
				last_tag  = disp_tag;
				last_told = disp_told;
				last_t1   = disp_t1;
				last_t2   = disp_t2;
			end
			@(posedge clock);
			#1;
		end
		inst_valid = 1'b0;
		inst       = '0;
		if (random_retire)
			retire_en = 1'b0;
		if (!taken)
			abort("instruction was never accepted");
	endtask

	task automatic send(input inst_t i, input bit random_retire);
		inst_valid = 1'b1;
		inst       = i;
		wait_accept(random_retire);
	endtask

	task automatic expect_rename(input tag_t t1, input tag_t t2, input tag_t tag, input tag_t told);
		check_val("disp_t1", 8'(last_t1), 8'(t1));
		check_val("disp_t2", 8'(last_t2), 8'(t2));
		check_val("disp_tag", 8'(last_tag), 8'(tag));
		check_val("disp_told", 8'(last_told), 8'(told));
	endtask

	task automatic drain();
		retire_en = 1'b1;
		for (int n = 0; n < WAIT_LIMIT && rob_q.size() != 0; n++) begin
			@(posedge clock);
			#1;
		end
		retire_en = 1'b0;
		if (rob_q.size() != 0)
			abort("reorder buffer did not drain");
	endtask

	initial begin
		logic [31:0] r;
		logic [6:0]  op;
		seed = 32'hb0c042db;
		errors = 0;
		checks = 0;
		test_base = 0;
		recycled = 0;
		reset = 1'b1;
		inst_valid = 1'b0;
		inst = '0;
		retire_en = 1'b0;
		arch_idx = '0;
		repeat (10) @(posedge clock);
		#1 reset = 1'b0;

		for (int i = 0; i < NUM_ARCH; i++) begin
			arch_idx = arch_reg_t'(i);  // identity map swept
			@(posedge clock);
			#1;
		end
		retire_en = 1'b1;  // nothing retires from an empty rob
		repeat (2) @(posedge clock);
		#1 retire_en = 1'b0;
		send(make_inst(OP_REG, 5'd5, 5'd1, 5'd2), 1'b0);
		expect_rename(6'd1, 6'd2, 6'd32, 6'd5);
		end_test("reset_state");

		send(make_inst(OP_REG, 5'd6, 5'd5, 5'd5), 1'b0);
		expect_rename(6'd32, 6'd32, 6'd33, 6'd6);
		send(make_inst(OP_REG, 5'd5, 5'd5, 5'd6), 1'b0);  // reads its own rd
		expect_rename(6'd32, 6'd33, 6'd34, 6'd32);
		send(make_inst(OP_IMM, 5'd6, 5'd5, 5'd0), 1'b0);
		expect_rename(6'd34, 6'd0, 6'd35, 6'd33);
		end_test("rename_chain");

		send(make_inst(OP_STORE, 5'd9, 5'd5, 5'd6), 1'b0);
		expect_rename(6'd34, 6'd35, 6'd0, 6'd0);
		send(make_inst(OP_BRANCH, 5'd3, 5'd6, 5'd5), 1'b0);
		expect_rename(6'd35, 6'd34, 6'd0, 6'd0);
		send(make_inst(OP_REG, 5'd0, 5'd5, 5'd6), 1'b0);
		expect_rename(6'd34, 6'd35, 6'd0, 6'd0);
		send(make_inst(OP_IMM, 5'd7, 5'd6, 5'd0), 1'b0);
		expect_rename(6'd35, 6'd0, 6'd36, 6'd7);
		end_test("no_destination");

		drain();
		for (int k = 0; k < ROB_DEPTH; k++)
			send(make_inst(OP_IMM, 5'(8 + k), 5'(k), 5'd0), 1'b0);
		inst_valid = 1'b1;
		inst = make_inst(OP_LOAD, 5'd20, 5'd1, 5'd0);  // ninth instruction held by the source
		repeat (3) begin
			@(negedge clock);
			check_val("stall", 8'(stall), 8'd1);
			check_val("disp_valid", 8'(disp_valid), 8'd0);
			@(posedge clock);
			#1;
		end
		retire_en = 1'b1;
		@(posedge clock);
		#1 retire_en = 1'b0;
		wait_accept(1'b0);
		end_test("back_pressure");

		drain();
		for (int k = 0; k < 64; k++) begin
			r = next_rand();
			case (r[31:16] % 5)
				0: op = OP_REG;
				1: op = OP_IMM;
				2: op = OP_LOAD;
				3: op = OP_STORE;
				default: op = OP_BRANCH;
			endcase
			arch_idx = r[30:26];
			send(make_inst(op, r[11:7], r[19:15], r[24:20]), 1'b1);
		end
		drain();
		checks++;
		assert (recycled > 0) else begin
			$display("no freed tag was ever allocated again");
			errors++;
		end
		end_test("retire_recycle");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* compile.f */
rename_pkg.sv
rename_if.sv
decoder.sv
free_list.sv
map_table.sv
dispatch.sv
rob.sv
retire.sv
rename_top.sv
rename_tb.sv

/* run.sh */
#!/bin/sh
# build and run the rename stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rename_tb -f compile.f -o rename_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/rename_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TB PASSED"; then
	exit 0
fi
exit 1
